// ==== access_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module access_ctrl (
  input  logic              clk,
  input  logic              rst,
  // arbitrated read
  input  npc_pkg::addr_t    rd_addr_i,
  input  logic              rd_valid_i,
  input  npc_pkg::mask_t    rd_mask_i,
  output npc_pkg::xlen_t    rd_data_o,
  output logic              rd_ready_o,
  // memory stage write
  input  npc_pkg::addr_t    wr_addr_i,
  input  logic              wr_valid_i,
  input  npc_pkg::mask_t    wr_mask_i,
  input  npc_pkg::xlen_t    wr_data_i,
  output logic              wr_ready_o,
  // single ram port
  output logic              ram_en_o,
  output logic              ram_we_o,
  output npc_pkg::ram_idx_t ram_idx_o,
  output npc_pkg::mask_t    ram_be_o,
  output npc_pkg::xlen_t    ram_wdata_o,
  input  npc_pkg::xlen_t    ram_rdata_i
);

  import npc_pkg::*;

  ctrl_state_e state;
  logic        wr_take;   // write waiting and not already acknowledged
  xlen_t       bit_mask;  // read mask widened to bits

  // the requester still shows valid in the cycle of its ready pulse
  assign wr_take = wr_valid_i & ~wr_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= CTRL_IDLE;
      ram_en_o   <= 1'b0;
      ram_we_o   <= 1'b0;
      wr_ready_o <= 1'b0;
    end else begin
      ram_en_o   <= 1'b0;  // single cycle strobes
      ram_we_o   <= 1'b0;
      wr_ready_o <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          if (wr_take) begin  // write beats read
            state    <= CTRL_WRITE;
            ram_en_o <= 1'b1;
            ram_we_o <= 1'b1;
          end else if (rd_valid_i) begin
            state    <= CTRL_READ;
            ram_en_o <= 1'b1;
          end
        end
        CTRL_READ:  state <= CTRL_RDATA;  // ram latches the word here
        CTRL_RDATA: state <= CTRL_IDLE;
        CTRL_WRITE: begin
          wr_ready_o <= 1'b1;
          state      <= CTRL_IDLE;
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  // ram address and write fields, loaded when an access starts
  always_ff @(posedge clk) begin
    if (state == CTRL_IDLE) begin
      if (wr_take) begin
        ram_idx_o   <= wr_addr_i[RAM_AW+2:3];
        ram_be_o    <= wr_mask_i;
        ram_wdata_o <= wr_data_i;
      end else begin
        ram_idx_o   <= rd_addr_i[RAM_AW+2:3];
        ram_be_o    <= rd_mask_i;
        ram_wdata_o <= '0;
      end
    end
  end

  always_comb begin
    for (int b = 0; b < MASK_W; b++) begin
      bit_mask[b*8 +: 8] = {8{rd_mask_i[b]}};
    end
  end

  // arbiter holds the mask until ready, so it is still good here
  assign rd_ready_o = (state == CTRL_RDATA);
  assign rd_data_o  = rd_ready_o ? (ram_rdata_i & bit_mask) : '0;

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram (
  input  logic              clk,
  input  logic              en_i,
  input  logic              we_i,
  input  npc_pkg::ram_idx_t idx_i,
  input  npc_pkg::mask_t    be_i,
  input  npc_pkg::xlen_t    wdata_i,
  output npc_pkg::xlen_t    rdata_o
);

  import npc_pkg::*;

  localparam int DEPTH = 2 ** RAM_AW;

  xlen_t mem [DEPTH];  // no reset, contents unknown until written

  // byte enabled write
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (be_i[b]) begin
          mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read data one cycle after the enable
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== mem_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys (
  input  logic           clk,
  input  logic           rst,
  // fetch read
  input  npc_pkg::addr_t if_read_addr_i,
  input  logic           if_raddr_valid_i,
  input  npc_pkg::mask_t if_rmask_i,
  output npc_pkg::xlen_t if_rdata_o,
  output logic           if_rdata_ready_o,
  // memory stage read
  input  npc_pkg::addr_t mem_read_addr_i,
  input  logic           mem_raddr_valid_i,
  input  npc_pkg::mask_t mem_rmask_i,
  output npc_pkg::xlen_t mem_rdata_o,
  output logic           mem_rdata_ready_o,
  // memory stage write
  input  npc_pkg::addr_t mem_write_addr_i,
  input  logic           mem_write_valid_i,
  input  npc_pkg::mask_t mem_wmask_i,
  input  npc_pkg::xlen_t mem_wdata_i,
  output logic           mem_wdata_ready_o
);

  import npc_pkg::*;

  // arbiter to controller
  addr_t    arb_read_addr;
  logic     arb_raddr_valid;
  mask_t    arb_rmask;
  xlen_t    arb_rdata;
  logic     arb_rdata_ready;
  addr_t    arb_write_addr;
  logic     arb_write_valid;
  mask_t    arb_wmask;
  xlen_t    arb_wdata;
  logic     arb_wdata_ready;

  // controller to ram
  logic     ram_en;
  logic     ram_we;
  ram_idx_t ram_idx;
  mask_t    ram_be;
  xlen_t    ram_wdata;
  xlen_t    ram_rdata;

  read_arb u_read_arb (
    .clk, .rst,
    .if_read_addr_i, .if_raddr_valid_i, .if_rmask_i, .if_rdata_o, .if_rdata_ready_o,
    .mem_read_addr_i, .mem_raddr_valid_i, .mem_rmask_i, .mem_rdata_o, .mem_rdata_ready_o,
    .mem_write_addr_i, .mem_write_valid_i, .mem_wmask_i, .mem_wdata_i, .mem_wdata_ready_o,
    .arb_read_addr_o   (arb_read_addr),
    .arb_raddr_valid_o (arb_raddr_valid),
    .arb_rmask_o       (arb_rmask),
    .arb_rdata_i       (arb_rdata),
    .arb_rdata_ready_i (arb_rdata_ready),
    .arb_write_addr_o  (arb_write_addr),
    .arb_write_valid_o (arb_write_valid),
    .arb_wmask_o       (arb_wmask),
    .arb_wdata_o       (arb_wdata),
    .arb_wdata_ready_i (arb_wdata_ready)
  );

  access_ctrl u_access_ctrl (
    .clk, .rst,
    .rd_addr_i  (arb_read_addr),
    .rd_valid_i (arb_raddr_valid),
    .rd_mask_i  (arb_rmask),
    .rd_data_o  (arb_rdata),
    .rd_ready_o (arb_rdata_ready),
    .wr_addr_i  (arb_write_addr),
    .wr_valid_i (arb_write_valid),
    .wr_mask_i  (arb_wmask),
    .wr_data_i  (arb_wdata),
    .wr_ready_o (arb_wdata_ready),
    .ram_en_o   (ram_en),
    .ram_we_o   (ram_we),
    .ram_idx_o  (ram_idx),
    .ram_be_o   (ram_be),
    .ram_wdata_o(ram_wdata),
    .ram_rdata_i(ram_rdata)
  );

  data_ram u_data_ram (
    .clk,
    .en_i    (ram_en),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== npc_pkg.sv ====
`default_nettype none

package npc_pkg;

  // widths
  localparam int XLEN   = 64;
  localparam int ADDR_W = 32;
  localparam int MASK_W = 8;   // one enable per byte
  localparam int RAM_AW = 10;  // 1024 words

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [MASK_W-1:0] mask_t;     // bit n enables byte n
  typedef logic [RAM_AW-1:0] ram_idx_t;

  // read arbiter states
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IF_READ,   // fetch holds the grant
    ARB_MEM_READ   // memory stage holds the grant
  } arb_state_e;

  // memory port sequencer states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_READ,   // ram read issued
    CTRL_RDATA,  // ram data back, ready pulse
    CTRL_WRITE   // ram write issued
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== read_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_arb (
  input  logic           clk,
  input  logic           rst,
  // fetch read port
  input  npc_pkg::addr_t if_read_addr_i,
  input  logic           if_raddr_valid_i,
  input  npc_pkg::mask_t if_rmask_i,
  output npc_pkg::xlen_t if_rdata_o,
  output logic           if_rdata_ready_o,
  // memory stage read port
  input  npc_pkg::addr_t mem_read_addr_i,
  input  logic           mem_raddr_valid_i,
  input  npc_pkg::mask_t mem_rmask_i,
  output npc_pkg::xlen_t mem_rdata_o,
  output logic           mem_rdata_ready_o,
  // memory stage write port
  input  npc_pkg::addr_t mem_write_addr_i,
  input  logic           mem_write_valid_i,
  input  npc_pkg::mask_t mem_wmask_i,
  input  npc_pkg::xlen_t mem_wdata_i,
  output logic           mem_wdata_ready_o,
  // arbitrated read channel
  output npc_pkg::addr_t arb_read_addr_o,
  output logic           arb_raddr_valid_o,
  output npc_pkg::mask_t arb_rmask_o,
  input  npc_pkg::xlen_t arb_rdata_i,
  input  logic           arb_rdata_ready_i,
  // write channel
  output npc_pkg::addr_t arb_write_addr_o,
  output logic           arb_write_valid_o,
  output npc_pkg::mask_t arb_wmask_o,
  output npc_pkg::xlen_t arb_wdata_o,
  input  logic           arb_wdata_ready_i
);

  import npc_pkg::*;

  arb_state_e state;
  logic       if_sel;
  logic       mem_sel;

  assign if_sel  = (state == ARB_IF_READ);
  assign mem_sel = (state == ARB_MEM_READ);

  // grant fsm, fetch wins when both readers ask
  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= ARB_IDLE;
      arb_raddr_valid_o <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (if_raddr_valid_i) begin
            state             <= ARB_IF_READ;
            arb_raddr_valid_o <= 1'b1;
          end else if (mem_raddr_valid_i) begin
            state             <= ARB_MEM_READ;
            arb_raddr_valid_o <= 1'b1;
          end
        end
        ARB_IF_READ, ARB_MEM_READ: begin
          if (arb_rdata_ready_i) begin  // done, rearbitrate next cycle
            state             <= ARB_IDLE;
            arb_raddr_valid_o <= 1'b0;
          end
        end
        default: begin
          state             <= ARB_IDLE;
          arb_raddr_valid_o <= 1'b0;
        end
      endcase
    end
  end

  // granted request fields, held for the whole grant
  always_ff @(posedge clk) begin
    if (state == ARB_IDLE) begin
      if (if_raddr_valid_i) begin
        arb_read_addr_o <= if_read_addr_i;
        arb_rmask_o     <= if_rmask_i;
      end else begin
        arb_read_addr_o <= mem_read_addr_i;
        arb_rmask_o     <= mem_rmask_i;
      end
    end
  end

  // return path, only the granted reader sees anything
  assign if_rdata_o        = if_sel ? arb_rdata_i : '0;
  assign if_rdata_ready_o  = if_sel & arb_rdata_ready_i;
  assign mem_rdata_o       = mem_sel ? arb_rdata_i : '0;
  assign mem_rdata_ready_o = mem_sel & arb_rdata_ready_i;

  // write channel goes straight through
  assign arb_write_addr_o  = mem_write_addr_i;
  assign arb_write_valid_o = mem_write_valid_i;
  assign arb_wmask_o       = mem_wmask_i;
  assign arb_wdata_o       = mem_wdata_i;
  assign mem_wdata_ready_o = arb_wdata_ready_i;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/bash
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module tb_mem_subsys \
  -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed"; exit 1; }
grep -q "Test passed" sim.log && echo "simulation ok" || { cat sim.log; exit 1; }

// ==== tb_mem_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

  import npc_pkg::*;

  logic  clk;
  logic  rst;
  addr_t if_read_addr_i, mem_read_addr_i, mem_write_addr_i;
  mask_t if_rmask_i, mem_rmask_i, mem_wmask_i;
  xlen_t if_rdata_o, mem_rdata_o, mem_wdata_i;
  logic  if_raddr_valid_i, mem_raddr_valid_i, mem_write_valid_i;
  logic  if_rdata_ready_o, mem_rdata_ready_o, mem_wdata_ready_o;

  xlen_t ref_mem [ram_idx_t];  // memory model keyed by word index
  int    errors = 0;
  int    issued = 0;
  int    cyc = 0;
  int    if_pulses = 0, mem_pulses = 0, wr_pulses = 0;
  int    if_base, mem_base, wr_base;

  mem_subsys dut (.*);

  always #10 clk = ~clk;

  // ready pulse counters sampled mid cycle
  always @(negedge clk) begin
    if (if_rdata_ready_o === 1'b1) if_pulses <= if_pulses + 1;
    if (mem_rdata_ready_o === 1'b1) mem_pulses <= mem_pulses + 1;
    if (mem_wdata_ready_o === 1'b1) wr_pulses <= wr_pulses + 1;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > 200 + 20 * issued) begin
      $display("timeout: a request got no ready after %0d cycles", cyc);
      $display("summary: %0d errors, %0d requests issued", errors, issued);
      $display("Test failed");
      $finish;
    end
  end

  // bits 2..0 ignored and the index wraps at the memory size
  function automatic ram_idx_t word_of(addr_t a);
    return ram_idx_t'((a >> 3) % (2 ** RAM_AW));
  endfunction

  function automatic xlen_t expect_read(addr_t a, mask_t m);
    xlen_t w;
    w = ref_mem[word_of(a)];
    for (int b = 0; b < MASK_W; b++) begin
      if (!m[b]) w[b*8 +: 8] = 8'h00;
    end
    return w;
  endfunction

  function automatic void model_write(addr_t a, mask_t m, xlen_t d);
    xlen_t w;
    w = ref_mem.exists(word_of(a)) ? ref_mem[word_of(a)] : '0;
    for (int b = 0; b < MASK_W; b++) begin
      if (m[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    ref_mem[word_of(a)] = w;
  endfunction

  function automatic xlen_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  task automatic check_data(input string name, input xlen_t exp, input xlen_t got);
    if (got !== exp) begin
      errors++;
      $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_ready(input string name, input int exp, input int got);
    if (got < exp) begin
      errors++;
      $display("missing ready pulse on %s: wanted %0d, saw %0d", name, exp, got);
    end else if (got > exp) begin
      errors++;
      $display("extra ready pulse on %s: wanted %0d, saw %0d", name, exp, got);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int got);
    if (got != exp) begin
      errors++;
      $display("ERR %s latency expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  task automatic mark_pulses();
    if_base  = if_pulses;
    mem_base = mem_pulses;
    wr_base  = wr_pulses;
  endtask

  task automatic check_pulses(input int n_if, input int n_mem, input int n_wr);
    repeat (2) @(posedge clk);  // room for a stray late pulse
    check_ready("if_rdata_ready_o", n_if, if_pulses - if_base);
    check_ready("mem_rdata_ready_o", n_mem, mem_pulses - mem_base);
    check_ready("mem_wdata_ready_o", n_wr, wr_pulses - wr_base);
  endtask

  task automatic issue_write(input addr_t a, input mask_t m, input xlen_t d, output int lat);
    int n;
    n = 0;
    issued++;
    model_write(a, m, d);
    @(posedge clk);
    mem_write_addr_i  <= a;
    mem_wmask_i       <= m;
    mem_wdata_i       <= d;
    mem_write_valid_i <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (mem_wdata_ready_o !== 1'b1);
    lat = n - 1;  // counted from the edge that samples valid
    @(posedge clk);
    mem_write_valid_i <= 1'b0;
  endtask

  task automatic issue_read(input bit fetch, input addr_t a, input mask_t m,
                            output int lat, output int done_cyc);
    xlen_t exp;
    logic  rdy;
    int    n;
    exp = expect_read(a, m);
    n = 0;
    issued++;
    @(posedge clk);
    if (fetch) begin
      if_read_addr_i   <= a;
      if_rmask_i       <= m;
      if_raddr_valid_i <= 1'b1;
    end else begin
      mem_read_addr_i   <= a;
      mem_rmask_i       <= m;
      mem_raddr_valid_i <= 1'b1;
    end
    do begin
      @(negedge clk);
      n++;
      rdy = fetch ? if_rdata_ready_o : mem_rdata_ready_o;
    end while (rdy !== 1'b1);
    lat = n - 1;
    done_cyc = cyc;
    if (fetch) begin
      check_data("if_rdata_o", exp, if_rdata_o);
      check_data("mem_rdata_o", '0, mem_rdata_o);  // idle reader sees zero
    end else begin
      check_data("mem_rdata_o", exp, mem_rdata_o);
      check_data("if_rdata_o", '0, if_rdata_o);
    end
    @(posedge clk);
    if (fetch) begin
      if_raddr_valid_i <= 1'b0;
    end else begin
      mem_raddr_valid_i <= 1'b0;
    end
  endtask

  task automatic test_reset();
    mark_pulses();
    repeat (5) @(posedge clk);
    check_pulses(0, 0, 0);
  endtask

  task automatic test_write_read();
    addr_t a;
    int    lat;
    int    dc;
    for (int i = 0; i < 8; i++) begin
      a = $urandom();
      issue_write(a, 8'hff, rand_word(), lat);
      mark_pulses();
      issue_read(1'b1, a, 8'hff, lat, dc);
      check_pulses(1, 0, 0);
      mark_pulses();
      issue_read(1'b0, a, 8'hff, lat, dc);
      check_pulses(0, 1, 0);
    end
  endtask

  task automatic test_byte_masks();
    addr_t a;
    mask_t m;
    int    lat;
    int    dc;
    for (int i = 0; i < 4; i++) begin
      a = $urandom();
      m = mask_t'($urandom());
      issue_write(a, 8'hff, rand_word(), lat);
      issue_write(a, m, rand_word(), lat);
      issue_read(1'b0, a, 8'hff, lat, dc);
      issue_read(1'b1, a ^ 32'h5, m ^ 8'h3c, lat, dc);  // low address bits flipped
    end
  endtask

  task automatic test_fetch_priority();
    int lat_if, lat_mem, done_if, done_mem;
    issue_write(32'h0000_0100, 8'hff, rand_word(), lat_if);
    issue_write(32'h0000_0208, 8'hff, rand_word(), lat_if);
    fork
      issue_read(1'b1, 32'h0000_0100, 8'hff, lat_if, done_if);
      issue_read(1'b0, 32'h0000_0208, 8'hff, lat_mem, done_mem);
    join
    if (done_if >= done_mem) begin
      errors++;
      $display("fetch ready did not come before the memory-stage ready");
    end
  endtask

  task automatic test_write_priority();
    int lat_w, lat_if, lat_mem, done_if, done_mem;
    mark_pulses();
    fork
      issue_write(32'h0000_0310, 8'hff, rand_word(), lat_w);
      issue_read(1'b1, 32'h0000_0100, 8'hff, lat_if, done_if);
      issue_read(1'b0, 32'h0000_0208, 8'hff, lat_mem, done_mem);
    join
    check_pulses(1, 1, 1);
    issue_read(1'b0, 32'h0000_0310, 8'hff, lat_mem, done_mem);
    // write raised a cycle late reaches the controller with the granted read
    mark_pulses();
    fork
      begin
        @(posedge clk);
        issue_write(32'h0000_0318, 8'hff, rand_word(), lat_w);
      end
      issue_read(1'b1, 32'h0000_0100, 8'hff, lat_if, done_if);
    join
    check_latency("mem_wdata_ready_o", 2, lat_w);
    check_pulses(1, 0, 1);
    issue_read(1'b1, 32'h0000_0318, 8'hff, lat_if, done_if);
  endtask

  task automatic test_timing();
    int lat;
    int dc;
    issue_write(32'h0000_0418, 8'hff, rand_word(), lat);
    check_latency("mem_wdata_ready_o", 2, lat);
    issue_read(1'b1, 32'h0000_0418, 8'hff, lat, dc);
    check_latency("if_rdata_ready_o", 3, lat);
    issue_read(1'b0, 32'h0000_0418, 8'hff, lat, dc);
    check_latency("mem_rdata_ready_o", 3, lat);
  endtask

  initial begin
    void'($urandom(96));
    clk = 1'b0;
    rst <= 1'b1;
    if_read_addr_i <= '0;
    if_rmask_i <= '0;
    if_raddr_valid_i <= 1'b0;
    mem_read_addr_i <= '0;
    mem_rmask_i <= '0;
    mem_raddr_valid_i <= 1'b0;
    mem_write_addr_i <= '0;
    mem_wmask_i <= '0;
    mem_wdata_i <= '0;
    mem_write_valid_i <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_write_read();
    test_byte_masks();
    test_fetch_priority();
    test_write_priority();
    test_timing();
    $display("summary: %0d errors, %0d requests issued", errors, issued);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
npc_pkg.sv
data_ram.sv
read_arb.sv
access_ctrl.sv
mem_subsys.sv
tb_mem_subsys.sv
